// ==== verilog/fb_geometry_pkg.sv ====
package fb_geometry_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Buffer geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // One fetch block carries eight 16-bit parcels.
  localparam int lanes = 8;
  localparam int depth_blocks = 4;
  localparam int capacity = lanes * depth_blocks;
  localparam int parcel_width = 16;

  // Parcels presented to the extractor each cycle.
  localparam int window = 4;

  localparam int lane_bits = $clog2(lanes);
  localparam int slot_bits = $clog2(depth_blocks);

  // Fetch starts with one credit per block slot.
  localparam int init_credits = depth_blocks;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Index and count types
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [slot_bits-1:0] slot_idx_t;

  typedef logic [lane_bits-1:0] lane_idx_t;

  // Slot in the upper bits, lane in the lower bits.
  typedef logic [slot_bits+lane_bits-1:0] parcel_ptr_t;

  // Counts 0 to capacity inclusive.
  typedef logic [$clog2(capacity+1)-1:0] occupancy_t;

  // Counts 0 to window inclusive.
  typedef logic [$clog2(window+1)-1:0] consume_t;

endpackage

// ==== verilog/fb_types_pkg.sv ====
package fb_types_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Enums
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [1:0] {
    len_none,
    len_16,
    len_32
  } instr_len_e;

  // Refill waits for the first block after reset or a clear.
  typedef enum logic {
    st_refill,
    st_stream
  } refill_state_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Port structs
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Parcel i sits at data bits 16i upward. The pc low bits hold the start offset.
  typedef struct packed {
    logic                                                              valid;
    logic [31:0]                                                       pc;
    logic [fb_geometry_pkg::lanes*fb_geometry_pkg::parcel_width-1:0] data;
  } fetch_block_t;

  typedef struct packed {
    logic [fb_geometry_pkg::parcel_width-1:0] bits;
    logic [31:0]                              pc;
  } parcel_t;

  // Entry 0 is the oldest parcel.
  typedef parcel_t [fb_geometry_pkg::window-1:0] parcel_window_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] instr;
    instr_len_e  len;
  } issue_slot_t;

  typedef struct packed {
    issue_slot_t slot0;
    issue_slot_t slot1;
  } issue_pair_t;

endpackage

// ==== verilog/refill_fsm.sv ====
`timescale 1ns/1ns

module refill_fsm (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       clear,
  input  fb_types_pkg::fetch_block_t block,
  output logic                       accept,
  output logic                       flush,
  output logic                       start_load,
  output fb_geometry_pkg::lane_idx_t start_offset
);

  fb_types_pkg::refill_state_e state;
  fb_types_pkg::refill_state_e state_next;

  // A clear wins over a block arriving in the same cycle.
  assign accept = block.valid && !clear;
  assign flush = clear;

  // The first block after a clear sets the read point.
  assign start_load = accept && (state == fb_types_pkg::st_refill);

  // Byte offset within the block, halved, gives the first lane.
  assign start_offset = block.pc[fb_geometry_pkg::lane_bits:1];

  always_comb begin
    state_next = state;
    if (clear) begin
      state_next = fb_types_pkg::st_refill;
    end else if (start_load) begin
      state_next = fb_types_pkg::st_stream;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= fb_types_pkg::st_refill;
    end else begin
      state <= state_next;
    end
  end

  // Once streaming, no realign happens again until the next clear.
  assert property (
    @(posedge clock) disable iff (!reset)
    (state == fb_types_pkg::st_stream && !clear) |=> !start_load
  ) else $error("start_load outside refill");

endmodule

// ==== verilog/parcel_pointers.sv ====
`timescale 1ns/1ns

module parcel_pointers (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         accept,
  input  logic                         flush,
  input  logic                         start_load,
  input  fb_geometry_pkg::lane_idx_t   start_offset,
  input  fb_geometry_pkg::consume_t    consume,
  output fb_geometry_pkg::slot_idx_t   wr_slot,
  output fb_geometry_pkg::parcel_ptr_t rd_ptr,
  output fb_geometry_pkg::occupancy_t  occupancy,
  output logic                         credit_return
);

  fb_geometry_pkg::parcel_ptr_t rd_ptr_next;
  fb_geometry_pkg::occupancy_t  fill;
  fb_geometry_pkg::occupancy_t  occupancy_next;
  fb_geometry_pkg::slot_idx_t   rd_slot;
  fb_geometry_pkg::slot_idx_t   rd_slot_next;
  logic                         credit_next;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next pointer and count
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    fill = '0;
    if (accept) begin
      fill = fb_geometry_pkg::occupancy_t'(fb_geometry_pkg::lanes);
      // Parcels below the start offset never become readable.
      if (start_load) begin
        fill = fill - fb_geometry_pkg::occupancy_t'(start_offset);
      end
    end
    occupancy_next = occupancy + fill - fb_geometry_pkg::occupancy_t'(consume);
  end

  always_comb begin
    if (start_load) begin
      rd_ptr_next = {wr_slot, start_offset};
    end else begin
      rd_ptr_next = rd_ptr + fb_geometry_pkg::parcel_ptr_t'(consume);
    end
  end

  assign rd_slot = rd_ptr[fb_geometry_pkg::lane_bits +: fb_geometry_pkg::slot_bits];
  assign rd_slot_next = rd_ptr_next[fb_geometry_pkg::lane_bits +: fb_geometry_pkg::slot_bits];

  // A slot is free again once reading has moved past its last lane.
  assign credit_next = !start_load && (rd_slot_next != rd_slot);

  always_ff @(posedge clock) begin
    if (!reset || flush) begin
      wr_slot <= '0;
      rd_ptr <= '0;
      occupancy <= '0;
      credit_return <= 1'b0;
    end else begin
      if (accept) begin
        wr_slot <= wr_slot + fb_geometry_pkg::slot_idx_t'(1);
      end
      rd_ptr <= rd_ptr_next;
      occupancy <= occupancy_next;
      credit_return <= credit_next;
    end
  end

  // Fetch honours its credits, so the buffer can never overfill.
  assert property (
    @(posedge clock) disable iff (!reset)
    occupancy <= fb_geometry_pkg::capacity
  ) else $error("occupancy above capacity");

  // The extractor only takes parcels that are held.
  assert property (
    @(posedge clock) disable iff (!reset)
    fb_geometry_pkg::occupancy_t'(consume) <= occupancy
  ) else $error("consume above occupancy");

endmodule

// ==== verilog/parcel_banks.sv ====
`timescale 1ns/1ns

module parcel_banks (
  input  logic                           clock,
  input  logic                           accept,
  input  fb_types_pkg::fetch_block_t     block,
  input  fb_geometry_pkg::slot_idx_t     wr_slot,
  input  fb_geometry_pkg::parcel_ptr_t   rd_ptr,
  output fb_types_pkg::parcel_window_t   window
);

  localparam int pw = fb_geometry_pkg::parcel_width;
  localparam int base_bits = 32 - fb_geometry_pkg::lane_bits - 1;

  // One bank per lane, one entry per block slot.
  logic [pw-1:0] bank_mem [fb_geometry_pkg::lanes][fb_geometry_pkg::depth_blocks];

  // Each slot keeps the 16-byte aligned base of its block.
  logic [base_bits-1:0] slot_base [fb_geometry_pkg::depth_blocks];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Write side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clock) begin
    if (accept) begin
      for (int i = 0; i < fb_geometry_pkg::lanes; i++) begin
        bank_mem[i][wr_slot] <= block.data[i*pw +: pw];
      end
      slot_base[wr_slot] <= block.pc[31:32-base_bits];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Rotated read window
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Adding k to the full pointer carries into the slot field when the lane wraps.
  for (genvar k = 0; k < fb_geometry_pkg::window; k++) begin : g_read
    fb_geometry_pkg::parcel_ptr_t pos;
    fb_geometry_pkg::slot_idx_t   slot;
    fb_geometry_pkg::lane_idx_t   lane;

    assign pos = rd_ptr + fb_geometry_pkg::parcel_ptr_t'(k);
    assign slot = pos[fb_geometry_pkg::lane_bits +: fb_geometry_pkg::slot_bits];
    assign lane = pos[fb_geometry_pkg::lane_bits-1:0];

    // A parcel's pc is its slot base plus twice its lane.
    assign window[k] = '{
      bits: bank_mem[lane][slot],
      pc:   {slot_base[slot], lane, 1'b0}
    };
  end

endmodule

// ==== verilog/instr_extract.sv ====
`timescale 1ns/1ns

module instr_extract (
  input  fb_types_pkg::parcel_window_t window,
  input  fb_geometry_pkg::occupancy_t  occupancy,
  input  logic                         stall,
  output fb_types_pkg::issue_pair_t    issue,
  output fb_geometry_pkg::consume_t    consume
);

  fb_types_pkg::issue_slot_t  first;
  fb_types_pkg::issue_slot_t  second;
  fb_geometry_pkg::consume_t  len0;
  fb_geometry_pkg::consume_t  len1;
  logic                       valid0;
  logic                       valid1;

  // Builds an instruction starting at lo. The upper half is only used for 32-bit ones.
  function automatic fb_types_pkg::issue_slot_t decode_slot(
    input fb_types_pkg::parcel_t lo,
    input fb_types_pkg::parcel_t hi
  );
    fb_types_pkg::issue_slot_t slot;
    slot.valid = 1'b0;
    slot.pc = lo.pc;
    if (lo.bits[1:0] == 2'b11) begin
      slot.instr = {hi.bits, lo.bits};
      slot.len = fb_types_pkg::len_32;
    end else begin
      slot.instr = {16'b0, lo.bits};
      slot.len = fb_types_pkg::len_16;
    end
    return slot;
  endfunction

  function automatic fb_geometry_pkg::consume_t parcels_of(
    input fb_types_pkg::instr_len_e len
  );
    case (len)
      fb_types_pkg::len_32: return fb_geometry_pkg::consume_t'(2);
      fb_types_pkg::len_16: return fb_geometry_pkg::consume_t'(1);
      default:              return '0;
    endcase
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Pairing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign first = decode_slot(window[0], window[1]);
  assign len0 = parcels_of(first.len);

  // The second instruction begins right after the first one.
  assign second = (first.len == fb_types_pkg::len_32) ?
                  decode_slot(window[2], window[3]) :
                  decode_slot(window[1], window[2]);
  assign len1 = parcels_of(second.len);

  assign valid0 = !stall && (occupancy >= fb_geometry_pkg::occupancy_t'(len0));
  assign valid1 = valid0 && (occupancy >= fb_geometry_pkg::occupancy_t'(len0 + len1));

  always_comb begin
    issue.slot0 = first;
    issue.slot0.valid = valid0;
    if (!valid0) begin
      issue.slot0.len = fb_types_pkg::len_none;
    end
    issue.slot1 = second;
    issue.slot1.valid = valid1;
    if (!valid1) begin
      issue.slot1.len = fb_types_pkg::len_none;
    end
  end

  always_comb begin
    consume = '0;
    if (valid0) begin
      consume = len0;
    end
    if (valid1) begin
      consume = consume + len1;
    end
  end

endmodule

// ==== verilog/fetch_buffer.sv ====
`timescale 1ns/1ns

module fetch_buffer (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       clear,
  input  logic                       stall,
  input  fb_types_pkg::fetch_block_t block,
  output logic                       credit_return,
  output fb_types_pkg::issue_pair_t  issue
);

  logic                         accept;
  logic                         flush;
  logic                         start_load;
  fb_geometry_pkg::lane_idx_t   start_offset;
  fb_geometry_pkg::slot_idx_t   wr_slot;
  fb_geometry_pkg::parcel_ptr_t rd_ptr;
  fb_geometry_pkg::occupancy_t  occupancy;
  fb_geometry_pkg::consume_t    consume;
  fb_types_pkg::parcel_window_t window;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  refill_fsm refill_fsm_inst (
    .clock        (clock),
    .reset        (reset),
    .clear        (clear),
    .block        (block),
    .accept       (accept),
    .flush        (flush),
    .start_load   (start_load),
    .start_offset (start_offset)
  );

  parcel_pointers parcel_pointers_inst (
    .clock         (clock),
    .reset         (reset),
    .accept        (accept),
    .flush         (flush),
    .start_load    (start_load),
    .start_offset  (start_offset),
    .consume       (consume),
    .wr_slot       (wr_slot),
    .rd_ptr        (rd_ptr),
    .occupancy     (occupancy),
    .credit_return (credit_return)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Datapath
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  parcel_banks parcel_banks_inst (
    .clock   (clock),
    .accept  (accept),
    .block   (block),
    .wr_slot (wr_slot),
    .rd_ptr  (rd_ptr),
    .window  (window)
  );

  instr_extract instr_extract_inst (
    .window    (window),
    .occupancy (occupancy),
    .stall     (stall),
    .issue     (issue),
    .consume   (consume)
  );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  localparam int half_period = 20;
  localparam int reset_cycles = 10;

  initial begin
    clock = 1'b0;
    forever begin
      #half_period clock = ~clock;
    end
  end

  // Reset is active low and lets go on a falling edge.
  initial begin
    reset = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
  end

endmodule

// ==== tb/fetch_buffer_tb.sv ====
`timescale 1ns/1ns

module fetch_buffer_tb;

  localparam int pw = fb_geometry_pkg::parcel_width;
  localparam int lanes = fb_geometry_pkg::lanes;
  localparam int block_bits = lanes * pw;
  localparam int drain_limit = 400;
  localparam int reset_limit = 40;

  logic                       clock;
  logic                       reset;
  logic                       clear;
  logic                       stall;
  fb_types_pkg::fetch_block_t block;
  logic                       credit_return;
  fb_types_pkg::issue_pair_t  issue;

  // The reference model holds the buffer's parcels, oldest first.
  fb_types_pkg::parcel_t  model_q[$];
  logic [block_bits-1:0]  pend_data[$];
  logic [31:0]            pend_pc[$];
  logic                   model_refill;
  int                     credits;
  int                     credit_pulses;
  int                     issued;
  int                     expected_instrs;
  logic [31:0]            first_pc;
  logic                   first_seen;
  logic [31:0]            rng_state;
  int                     errors;
  int                     test_errors;
  int                     tests_run;
  string                  test_name;

  tb_clock_gen tb_clock_gen_inst (
    .clock (clock),
    .reset (reset)
  );

  fetch_buffer fetch_buffer_inst (
    .clock         (clock),
    .reset         (reset),
    .clear         (clear),
    .stall         (stall),
    .block         (block),
    .credit_return (credit_return),
    .issue         (issue)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus generation
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Low bits 00, 01 or 10 mark a compressed instruction.
  function automatic logic [15:0] short_parcel();
    logic [31:0] r;
    r = next_random();
    return {r[15:2], r[17:16] % 2'd3};
  endfunction

  // Queues blocks from base. Lanes of the first block below first_lane hold filler.
  task automatic build_stream(input logic [31:0] base, input int nblocks,
                              input int first_lane, input logic long_only);
    logic [15:0]           parcels[$];
    logic [31:0]           r;
    logic [block_bits-1:0] data;
    int                    total;
    total = nblocks * lanes;
    for (int i = 0; i < first_lane; i++) begin
      r = next_random();
      parcels.push_back({r[15:2], 2'b11});
    end
    while (parcels.size() < total) begin
      r = next_random();
      // A 32-bit instruction never starts on the very last parcel.
      if ((long_only || r[20]) && parcels.size() < total - 1) begin
        parcels.push_back({r[15:2], 2'b11});
        parcels.push_back(r[31:16]);
      end else begin
        parcels.push_back(short_parcel());
      end
      expected_instrs++;
    end
    for (int b = 0; b < nblocks; b++) begin
      for (int l = 0; l < lanes; l++) begin
        data[l*pw +: pw] = parcels[b*lanes + l];
      end
      pend_data.push_back(data);
      pend_pc.push_back(base + 32'(16 * b) + ((b == 0) ? 32'(2 * first_lane) : 32'd0));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic int parcels_needed(input logic [15:0] bits);
    return (bits[1:0] == 2'b11) ? 2 : 1;
  endfunction

  task automatic model_accept(input logic [31:0] pc, input logic [block_bits-1:0] data);
    fb_types_pkg::parcel_t p;
    int                    start;
    // The first block after a clear starts at its pc offset.
    start = model_refill ? int'(pc[3:1]) : 0;
    model_refill = 1'b0;
    for (int l = start; l < lanes; l++) begin
      p.bits = data[l*pw +: pw];
      p.pc = {pc[31:4], 4'b0} + 32'(2 * l);
      model_q.push_back(p);
    end
  endtask

  function automatic fb_types_pkg::issue_slot_t predict_slot(input int pos,
                                                             input logic allowed);
    fb_types_pkg::issue_slot_t s;
    logic [15:0]               lo;
    s = '0;
    s.len = fb_types_pkg::len_none;
    if (allowed && pos < model_q.size()) begin
      lo = model_q[pos].bits;
      if (pos + parcels_needed(lo) <= model_q.size()) begin
        s.valid = 1'b1;
        s.pc = model_q[pos].pc;
        if (parcels_needed(lo) == 2) begin
          s.instr = {model_q[pos+1].bits, lo};
          s.len = fb_types_pkg::len_32;
        end else begin
          s.instr = {16'b0, lo};
          s.len = fb_types_pkg::len_16;
        end
      end
    end
    return s;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks and cycle driver
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic compare_slot(input string what, input fb_types_pkg::issue_slot_t expected,
                              input fb_types_pkg::issue_slot_t actual);
    logic  bad;
    string exp_text;
    string act_text;
    bad = (expected.valid !== actual.valid) || (expected.len !== actual.len);
    if (expected.valid) begin
      bad = bad || (expected.pc !== actual.pc) || (expected.instr !== actual.instr);
    end
    if (bad) begin
      exp_text = $sformatf("valid=%0b pc=%h instr=%h len=%0d",
                           expected.valid, expected.pc, expected.instr, expected.len);
      act_text = $sformatf("valid=%0b pc=%h instr=%h len=%0d",
                           actual.valid, actual.pc, actual.instr, actual.len);
      $display("mismatch %s %s expected %s actual %s", test_name, what, exp_text, act_text);
      test_errors++;
    end
  endtask

  task automatic compare_count(input string what, input int expected, input int actual);
    if (expected != actual) begin
      $display("mismatch %s %s expected %0d actual %0d", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  // Drives one cycle at the falling edge and checks the pair offered to decode.
  task automatic step(input logic stall_in, input logic clear_in);
    fb_types_pkg::issue_slot_t exp0;
    fb_types_pkg::issue_slot_t exp1;
    logic                      send;
    @(negedge clock);
    if (credit_return) begin
      credits++;
      credit_pulses++;
    end
    send = !clear_in && pend_data.size() > 0 && credits > 0;
    stall = stall_in;
    clear = clear_in;
    block = '0;
    if (send) begin
      block.valid = 1'b1;
      block.pc = pend_pc[0];
      block.data = pend_data[0];
      credits--;
    end
    #1;
    exp0 = predict_slot(0, !stall_in);
    exp1 = predict_slot(exp0.valid ? parcels_needed(exp0.instr[15:0]) : 0, exp0.valid);
    compare_slot("slot0", exp0, issue.slot0);
    compare_slot("slot1", exp1, issue.slot1);
    if (issue.slot0.valid === 1'b1) begin
      issued++;
      if (!first_seen) begin
        first_pc = issue.slot0.pc;
        first_seen = 1'b1;
      end
    end
    if (issue.slot1.valid === 1'b1) begin
      issued++;
    end
    // Offered instructions are taken at the coming edge.
    if (exp0.valid) begin
      repeat (parcels_needed(exp0.instr[15:0])) void'(model_q.pop_front());
    end
    if (exp1.valid) begin
      repeat (parcels_needed(exp1.instr[15:0])) void'(model_q.pop_front());
    end
    if (clear_in) begin
      model_q.delete();
      model_refill = 1'b1;
      credits = fb_geometry_pkg::init_credits;
    end else if (send) begin
      model_accept(pend_pc.pop_front(), pend_data.pop_front());
    end
  endtask

  task automatic do_clear();
    step(1'b1, 1'b1);
    issued = 0;
    expected_instrs = 0;
    credit_pulses = 0;
    first_seen = 1'b0;
  endtask

  task automatic feed_stalled();
    int cycles;
    cycles = 0;
    while (pend_data.size() > 0 && cycles < drain_limit) begin
      step(1'b1, 1'b0);
      cycles++;
    end
    if (pend_data.size() > 0) begin
      $display("%s: fetch could not send its blocks in time", test_name);
      test_errors++;
    end
  endtask

  task automatic drain(input logic toggle);
    int          cycles;
    logic        st;
    logic [31:0] r;
    cycles = 0;
    while ((pend_data.size() > 0 || model_q.size() > 0) && cycles < drain_limit) begin
      st = 1'b0;
      if (toggle) begin
        r = next_random();
        st = r[5];
      end
      step(st, 1'b0);
      cycles++;
    end
    if (pend_data.size() > 0 || model_q.size() > 0) begin
      $display("%s: buffer did not drain within %0d cycles", test_name, drain_limit);
      test_errors++;
    end
    // The last credit shows up one cycle after the final parcels are taken.
    step(1'b0, 1'b0);
    step(1'b0, 1'b0);
    compare_count("instructions", expected_instrs, issued);
    compare_count("credits", fb_geometry_pkg::init_credits, credits);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("%s: %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "bad", test_errors);
    errors += test_errors;
    tests_run++;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic test_idle();
    begin_test("idle");
    repeat (20) step(1'b0, 1'b0);
    compare_count("credit pulses", 0, credit_pulses);
    compare_count("instructions", 0, issued);
    end_test();
  endtask

  task automatic test_long_pairs();
    begin_test("long_pairs");
    do_clear();
    build_stream(32'h1000, 6, 0, 1'b1);
    drain(1'b0);
    end_test();
  endtask

  task automatic test_random_mix();
    begin_test("random_mix");
    do_clear();
    build_stream(32'h4000, 8, 0, 1'b0);
    drain(1'b0);
    end_test();
  endtask

  task automatic test_realign();
    begin_test("realign");
    do_clear();
    build_stream(32'h3000, 2, 0, 1'b0);
    feed_stalled();
    do_clear();
    build_stream(32'h2000, 3, 3, 1'b0);
    drain(1'b0);
    compare_count("first pc", int'(32'h2006), int'(first_pc));
    end_test();
  endtask

  task automatic test_stall_credits();
    begin_test("stall_credits");
    do_clear();
    build_stream(32'h5000, 4, 0, 1'b0);
    feed_stalled();
    compare_count("credits held", 0, credits);
    drain(1'b0);
    compare_count("credit pulses", 4, credit_pulses);
    end_test();
  endtask

  task automatic test_stall_toggle();
    begin_test("stall_toggle");
    do_clear();
    build_stream(32'h6000, 8, 0, 1'b0);
    drain(1'b1);
    end_test();
  endtask

  initial begin
    int cycles;
    clear = 1'b0;
    stall = 1'b0;
    block = '0;
    rng_state = 32'd35993;
    model_refill = 1'b1;
    credits = fb_geometry_pkg::init_credits;
    credit_pulses = 0;
    issued = 0;
    expected_instrs = 0;
    first_pc = '0;
    first_seen = 1'b0;
    errors = 0;
    tests_run = 0;
    cycles = 0;
    while (reset !== 1'b1 && cycles < reset_limit) begin
      @(posedge clock);
      cycles++;
    end
    if (reset !== 1'b1) begin
      $display("reset was never released");
      errors++;
    end
    test_idle();
    test_long_pairs();
    test_random_mix();
    test_realign();
    test_stall_credits();
    test_stall_toggle();
    $display("tests %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
verilog/fb_geometry_pkg.sv
verilog/fb_types_pkg.sv
verilog/refill_fsm.sv
verilog/parcel_pointers.sv
verilog/parcel_banks.sv
verilog/instr_extract.sv
verilog/fetch_buffer.sv
tb/tb_clock_gen.sv
tb/fetch_buffer_tb.sv

// ==== Makefile ====
TOP = fetch_buffer_tb

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -qx 'sim passed'

clean:
	rm -rf obj_dir

.PHONY: sim clean
